// File: run_sim.sh
#!/bin/bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --top-module tb_proc -f tb.f -o tb_proc_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_proc_sim > sim.log 2>&1 || echo "Simulator returned an error status"

grep -qx "Finished with no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: sim/proc_props.sv
/* Bound into proc_top; checks the outgoing val/rdy ports only */
`timescale 1ns/100ps

module proc_props
(
  input logic                   clk,
  input logic                   arst_n,
  input proc_pkg::word_t        imemreq_addr,
  input logic                   imemreq_val,
  input logic                   imemreq_rdy,
  input proc_pkg::memreq_type_t dmemreq_type,
  input proc_pkg::word_t        dmemreq_addr,
  input proc_pkg::word_t        dmemreq_data,
  input logic                   dmemreq_val,
  input logic                   dmemreq_rdy,
  input proc_pkg::word_t        to_mngr_data,
  input logic                   to_mngr_val,
  input logic                   to_mngr_rdy
);

  // A blocked request keeps its payload
  imem_hold: assert property (@(posedge clk) disable iff (!arst_n)
    imemreq_val && !imemreq_rdy |=> imemreq_val && $stable(imemreq_addr))
    else $error("imemreq changed while blocked");

  dmem_hold: assert property (@(posedge clk) disable iff (!arst_n)
    dmemreq_val && !dmemreq_rdy |=> dmemreq_val && $stable(dmemreq_addr) &&
    $stable(dmemreq_data) && $stable(dmemreq_type))
    else $error("dmemreq changed while blocked");

  mngr_hold: assert property (@(posedge clk) disable iff (!arst_n)
    to_mngr_val && !to_mngr_rdy |=> to_mngr_val && $stable(to_mngr_data))
    else $error("to_mngr changed while blocked");

  quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> !to_mngr_val && !dmemreq_val)
    else $error("port valid high during reset");

endmodule

// File: sim/tb_proc.sv
/* Memories answer in order after 0 to 3 cycles; request rdy toggles at random
   Programs must end by falling off their last word; the rest of memory holds nops */
`timescale 1ns/100ps

module tb_proc;
  import proc_pkg::*;

  logic clk, arst_n;
  word_t imemreq_addr, imemresp_data, dmemreq_addr, dmemreq_data, dmemresp_data;
  logic imemreq_val, imemreq_rdy, imemresp_val, imemresp_rdy;
  memreq_type_t dmemreq_type;
  logic dmemreq_val, dmemreq_rdy, dmemresp_val, dmemresp_rdy;
  word_t from_mngr_data, to_mngr_data;
  logic from_mngr_val, from_mngr_rdy, to_mngr_val, to_mngr_rdy;

  word_t imem [256];
  word_t dmem [256];
  word_t prog [$];
  word_t src_words [$];
  word_t exp_words [$];
  word_t iq [$];
  word_t dq [$];
  logic [15:0] lfsr = 16'd28594;
  int idly, ddly, src_idx, got, cyc;
  logic i_fire, d_fire, s_fire, sink_slow;
  string cur_test;

  proc_top proc_top_inst (.*);

  bind proc_top proc_props props_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR, one step per bit
  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      r = (r << 1) | {31'd0, lfsr[0]};
    end
    return r;
  endfunction

  // ------------------------------------------------------------------
  // Assembler
  // ------------------------------------------------------------------

  function automatic word_t addu(input int rd, input int rs, input int rt);
    return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct_addu};
  endfunction
  function automatic word_t addiu(input int rt, input int rs, input int imm);
    return {op_addiu, 5'(rs), 5'(rt), 16'(imm)};
  endfunction
  function automatic word_t lw(input int rt, input int imm, input int rs);
    return {op_lw, 5'(rs), 5'(rt), 16'(imm)};
  endfunction
  function automatic word_t sw(input int rt, input int imm, input int rs);
    return {op_sw, 5'(rs), 5'(rt), 16'(imm)};
  endfunction
  function automatic word_t bne(input int rs, input int rt, input int off);
    return {op_bne, 5'(rs), 5'(rt), 16'(off)};
  endfunction
  function automatic word_t mfc0(input int rt);
    return {op_cop0, cop0_mf, 5'(rt), 16'd0};
  endfunction
  function automatic word_t mtc0(input int rt);
    return {op_cop0, cop0_mt, 5'(rt), 16'd0};
  endfunction

  function automatic word_t dmem_fill(input int i);
    return 32'hC0DE0000 ^ (32'(i) * 32'h00010004);
  endfunction

  // Instruction-level model of the program in prog
  function automatic void ref_run();
    word_t rf [32];
    word_t dm [256];
    word_t pc, inst, imm, a;
    int si;
    int steps;
    for (int i = 0; i < 32; i++)
      rf[i] = '0;
    for (int i = 0; i < 256; i++)
      dm[i] = dmem_fill(i);
    exp_words.delete();
    pc = '0;
    si = 0;
    steps = 0;
    while ((pc < 32'(prog.size() * 4)) && (steps < 10000))
    begin
      inst = prog[pc[9:2]];
      imm = {{16{inst[15]}}, inst[15:0]};
      a = rf[inst[25:21]] + imm;
      pc = pc + 32'd4;
      steps++;
      case (inst[31:26])
        op_special:
          if (inst[5:0] == funct_addu)
            rf[inst[15:11]] = rf[inst[25:21]] + rf[inst[20:16]];
        op_addiu: rf[inst[20:16]] = a;
        op_lw:    rf[inst[20:16]] = dm[a[9:2]];
        op_sw:    dm[a[9:2]] = rf[inst[20:16]];
        op_bne:
          if (rf[inst[25:21]] != rf[inst[20:16]])
            pc = pc + {imm[29:0], 2'b00};
        op_cop0:
          if (inst[25:21] == cop0_mf)
          begin
            rf[inst[20:16]] = src_words[si];
            si++;
          end
          else if (inst[25:21] == cop0_mt)
            exp_words.push_back(rf[inst[20:16]]);
        default: ;
      endcase
      rf[0] = '0;
    end
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual)
    begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------------
  // Memory and stream models
  // ------------------------------------------------------------------

  always @(posedge clk)
    if (!arst_n)
    begin
      iq.delete();
      dq.delete();
      i_fire = 1'b0;
      d_fire = 1'b0;
      s_fire = 1'b0;
    end
    else
    begin
      if (imemreq_val && imemreq_rdy)
        iq.push_back(imem[imemreq_addr[9:2]]);
      if (dmemreq_val && dmemreq_rdy)
      begin
        if (dmemreq_type == memreq_write)
          dmem[dmemreq_addr[9:2]] = dmemreq_data;
        else
          dq.push_back(dmem[dmemreq_addr[9:2]]);
      end
      i_fire = imemresp_val && imemresp_rdy;
      d_fire = dmemresp_val && dmemresp_rdy;
      s_fire = from_mngr_val && from_mngr_rdy;
    end

  always @(negedge clk)
    if (!arst_n)
    begin
      imemreq_rdy = 1'b0;
      dmemreq_rdy = 1'b0;
      imemresp_val = 1'b0;
      dmemresp_val = 1'b0;
      from_mngr_val = 1'b0;
      to_mngr_rdy = 1'b0;
      idly = 0;
      ddly = 0;
      src_idx = 0;
    end
    else
    begin
      // Request ports stall at random too
      imemreq_rdy = (rand_bits(1) != 0);
      dmemreq_rdy = (rand_bits(1) != 0);
      if (i_fire)
      begin
        void'(iq.pop_front());
        imemresp_val = 1'b0;
        idly = int'(rand_bits(2));
      end
      if (!imemresp_val && (iq.size() > 0))
      begin
        if (idly == 0)
        begin
          imemresp_val = 1'b1;
          imemresp_data = iq[0];
        end
        else
          idly--;
      end
      if (d_fire)
      begin
        void'(dq.pop_front());
        dmemresp_val = 1'b0;
        ddly = int'(rand_bits(2));
      end
      if (!dmemresp_val && (dq.size() > 0))
      begin
        if (ddly == 0)
        begin
          dmemresp_val = 1'b1;
          dmemresp_data = dq[0];
        end
        else
          ddly--;
      end
      if (s_fire)
      begin
        src_idx++;
        from_mngr_val = 1'b0;
      end
      if (!from_mngr_val && (src_idx < src_words.size()) && (rand_bits(1) != 0))
      begin
        from_mngr_val = 1'b1;
        from_mngr_data = src_words[src_idx];
      end
      cyc++;
      // Slow sink is closed for most of every 48-cycle window
      if (sink_slow)
        to_mngr_rdy = ((cyc % 48) >= 36) && (rand_bits(1) != 0);
      else
        to_mngr_rdy = (rand_bits(1) != 0);
    end

  // Compare process
  always @(posedge clk)
    if (arst_n && to_mngr_val && to_mngr_rdy)
    begin
      if (got >= exp_words.size())
      begin
        $display("Test %s produced more outputs than expected", cur_test);
        $display("Finished with errors");
        $fatal(1);
      end
      check_word(cur_test, exp_words[got], to_mngr_data);
      got++;
    end

  task automatic run_prog(input string name, input logic slow);
    int t;
    sink_slow = slow;
    @(negedge clk);
    arst_n <= 1'b0;
    for (int i = 0; i < 256; i++)
    begin
      imem[i] = (i < prog.size()) ? prog[i] : '0;
      dmem[i] = dmem_fill(i);
    end
    ref_run();
    cur_test = name;
    got = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n <= 1'b1;
    t = 0;
    while (got < exp_words.size())
    begin
      @(negedge clk);
      t++;
      if (t > 20000)
      begin
        $display("Timeout in test %s after %0d of %0d outputs", name, got,
                 exp_words.size());
        $display("Finished with errors");
        $fatal(1);
      end
    end
    // Room for any extra output to show up
    repeat (30) @(posedge clk);
  endtask

  initial
  begin
    arst_n = 1'b0;
    imemreq_rdy = 1'b1;
    dmemreq_rdy = 1'b1;
    imemresp_val = 1'b0;
    imemresp_data = '0;
    dmemresp_val = 1'b0;
    dmemresp_data = '0;
    from_mngr_val = 1'b0;
    from_mngr_data = '0;
    to_mngr_rdy = 1'b0;
    sink_slow = 1'b0;
    cyc = 0;
    got = 0;
    src_idx = 0;

    prog.delete();
    src_words.delete();
    for (int i = 0; i < 8; i++)
    begin
      prog.push_back(mfc0(1));
      prog.push_back(mtc0(1));
      src_words.push_back(rand_bits(32));
    end
    run_prog("echo", 1'b0);

    prog = '{mfc0(1), addiu(2, 1, 5), addu(3, 2, 1), addiu(3, 3, -7), addu(4, 3, 3),
             mtc0(2), mtc0(3), mtc0(4)};
    src_words = '{32'h0000_1234};
    run_prog("raw_chain", 1'b0);

    prog = '{addiu(1, 0, 64), addiu(2, 0, 4660), sw(2, 0, 1), addiu(3, 0, -3),
             sw(3, 4, 1), lw(4, 0, 1), lw(5, 4, 1), lw(6, 8, 1), mtc0(4), mtc0(5),
             mtc0(6)};
    run_prog("store_load", 1'b0);

    // Word after bne is wrong-path on every taken iteration
    prog = '{addiu(1, 0, 5), addiu(2, 0, 0), addiu(2, 2, 3), addiu(1, 1, -1),
             bne(1, 0, -3), mtc0(2), mtc0(1)};
    run_prog("bne_loop", 1'b0);

    src_words.delete();
    for (int i = 0; i < 12; i++)
      src_words.push_back(rand_bits(32));
    prog = '{addiu(1, 0, 12), addiu(4, 0, 0), mfc0(3), addu(4, 4, 3), mtc0(4),
             addiu(1, 1, -1), bne(1, 0, -5), mtc0(1)};
    run_prog("back_pressure", 1'b1);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: source/proc_ctrl.sv
/* No bypassing: a source register waits until its producer has left W
   At most two fetches are outstanding; a taken bne in X drops their responses */
`timescale 1ns/100ps

module proc_ctrl
(
  input  logic                   clk,
  input  logic                   arst_n,
  output logic                   fetch_val,
  input  logic                   fetch_rdy,
  input  logic                   imemresp_val,
  output logic                   imemresp_rdy,
  output logic                   dmemreq_val,
  output proc_pkg::memreq_type_t dmemreq_type,
  input  logic                   dmemreq_rdy,
  input  logic                   dmemresp_val,
  output logic                   dmemresp_rdy,
  input  logic                   from_mngr_val,
  output logic                   from_mngr_rdy,
  output logic                   to_mngr_val,
  input  logic                   to_mngr_rdy,
  input  proc_pkg::word_t        inst_d,
  input  logic                   br_cond_eq_x,
  output proc_pkg::pc_sel_e      pc_sel_f,
  output logic                   reg_en_f,
  output logic                   reg_en_d,
  output logic                   reg_en_x,
  output logic                   reg_en_m,
  output logic                   reg_en_w,
  output logic                   op1_sel_d,
  output logic                   mngr_sel_d,
  output logic                   wb_sel_m,
  output proc_pkg::alu_fn_e      alu_fn_x,
  output proc_pkg::reg_addr_t    rf_waddr_w,
  output logic                   rf_wen_w
);
  import proc_pkg::*;

  // Fetch bookkeeping
  logic       fetch_on;
  logic [1:0] out_cnt;
  logic [1:0] drop_cnt;
  logic       fetch_go;
  logic       resp_go;
  logic       resp_drop;
  logic       live_resp_go;

  // Decode
  logic [5:0] op_d;
  logic [5:0] funct_d;
  reg_addr_t  rs_d;
  reg_addr_t  rt_d;
  reg_addr_t  rd_d;
  logic       is_addu_d;
  logic       is_addiu_d;
  logic       is_lw_d;
  logic       is_sw_d;
  logic       is_bne_d;
  logic       is_mfc0_d;
  logic       is_mtc0_d;
  logic       rs_en_d;
  logic       rt_en_d;
  logic       wen_d;
  reg_addr_t  waddr_d;
  alu_fn_e    alu_fn_d;

  // Per-stage state
  logic       val_d, val_x, val_m, val_w;
  logic       wen_x, wen_m, wen_w;
  reg_addr_t  waddr_x, waddr_m, waddr_w;
  logic       bne_x, lw_x, sw_x, lw_m;
  logic       mtc0_x, mtc0_m, mtc0_w;

  logic       raw_rs, raw_rt;
  logic       squash;
  logic       stall_d, stall_x, stall_m, stall_w;

  // ------------------------------------------------------------------
  // Decode in D
  // ------------------------------------------------------------------

  assign op_d    = inst_d[31:26];
  assign rs_d    = inst_d[25:21];
  assign rt_d    = inst_d[20:16];
  assign rd_d    = inst_d[15:11];
  assign funct_d = inst_d[5:0];

  assign is_addu_d  = (op_d == op_special) && (funct_d == funct_addu);
  assign is_addiu_d = (op_d == op_addiu);
  assign is_lw_d    = (op_d == op_lw);
  assign is_sw_d    = (op_d == op_sw);
  assign is_bne_d   = (op_d == op_bne);
  assign is_mfc0_d  = (op_d == op_cop0) && (rs_d == cop0_mf);
  assign is_mtc0_d  = (op_d == op_cop0) && (rs_d == cop0_mt);

  assign rs_en_d = is_addu_d || is_addiu_d || is_lw_d || is_sw_d || is_bne_d;
  assign rt_en_d = is_addu_d || is_sw_d || is_bne_d || is_mtc0_d;
  assign waddr_d = is_addu_d ? rd_d : rt_d;
  // Writes to r0 are dropped here so they never cause a hazard
  assign wen_d   = (is_addu_d || is_addiu_d || is_lw_d || is_mfc0_d) && (waddr_d != 5'd0);

  assign op1_sel_d  = is_addiu_d || is_lw_d || is_sw_d;
  assign mngr_sel_d = is_mfc0_d;

  always_comb
  begin
    if (is_bne_d)
      alu_fn_d = alu_cmp_eq;
    else if (is_mfc0_d || is_mtc0_d)
      alu_fn_d = alu_cp_op1;
    else
      alu_fn_d = alu_add;
  end

  // RAW against every later stage that will write the register file
  assign raw_rs = rs_en_d && ((val_x && wen_x && (waddr_x == rs_d)) ||
                              (val_m && wen_m && (waddr_m == rs_d)) ||
                              (val_w && wen_w && (waddr_w == rs_d)));
  assign raw_rt = rt_en_d && ((val_x && wen_x && (waddr_x == rt_d)) ||
                              (val_m && wen_m && (waddr_m == rt_d)) ||
                              (val_w && wen_w && (waddr_w == rt_d)));

  // ------------------------------------------------------------------
  // Stalls, from the back of the pipe forward
  // ------------------------------------------------------------------

  assign stall_w = val_w && mtc0_w && !to_mngr_rdy;
  assign stall_m = val_m && ((lw_m && !dmemresp_val) || stall_w);
  assign stall_x = val_x && (((lw_x || sw_x) && !dmemreq_rdy) || stall_m);
  assign stall_d = val_d && (raw_rs || raw_rt || (is_mfc0_d && !from_mngr_val) || stall_x);

  // Branch resolves only as the bne leaves X
  assign squash = val_x && bne_x && !br_cond_eq_x && !stall_x;

  // ------------------------------------------------------------------
  // Fetch and instruction response
  // ------------------------------------------------------------------

  assign fetch_val    = fetch_on && (out_cnt != 2'd2) && !squash;
  assign fetch_go     = fetch_val && fetch_rdy;
  assign resp_drop    = (drop_cnt != 2'd0);
  assign imemresp_rdy = (out_cnt != 2'd0) && (resp_drop || !stall_d);
  assign resp_go      = imemresp_val && imemresp_rdy;
  assign live_resp_go = resp_go && !resp_drop;

  assign pc_sel_f = squash ? pc_branch : pc_plus4;
  assign reg_en_f = fetch_go || squash;
  assign reg_en_d = live_resp_go;
  assign reg_en_x = !stall_x;
  assign reg_en_m = !stall_m;
  assign reg_en_w = !stall_w;

  // ------------------------------------------------------------------
  // Port handshakes
  // ------------------------------------------------------------------

  assign from_mngr_rdy = val_d && is_mfc0_d && !stall_x && !squash;
  assign dmemreq_val   = val_x && (lw_x || sw_x) && !stall_m;
  assign dmemreq_type  = sw_x ? memreq_write : memreq_read;
  assign dmemresp_rdy  = val_m && lw_m && !stall_w;
  assign to_mngr_val   = val_w && mtc0_w;
  assign wb_sel_m      = lw_m;
  assign rf_waddr_w    = waddr_w;
  assign rf_wen_w      = val_w && wen_w;

  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      fetch_on <= 1'b0;
      out_cnt  <= 2'd0;
      drop_cnt <= 2'd0;
      val_d    <= 1'b0;
      val_x    <= 1'b0;
      val_m    <= 1'b0;
      val_w    <= 1'b0;
    end
    else
    begin
      fetch_on <= 1'b1;
      out_cnt  <= out_cnt + {1'b0, fetch_go} - {1'b0, resp_go};
      // Everything still in flight after a taken branch is wrong-path
      if (squash)
        drop_cnt <= out_cnt - {1'b0, resp_go};
      else if (resp_go && resp_drop)
        drop_cnt <= drop_cnt - 2'd1;
      if (squash)
        val_d <= 1'b0;
      else if (!stall_d)
        val_d <= live_resp_go;
      if (!stall_x)
        val_x <= val_d && !stall_d && !squash;
      if (!stall_m)
        val_m <= val_x && !stall_x;
      if (!stall_w)
        val_w <= val_m && !stall_m;
    end

  // Stage payload, qualified by the valid bits above
  always_ff @(posedge clk)
  begin
    if (reg_en_x)
    begin
      wen_x    <= wen_d;
      waddr_x  <= waddr_d;
      bne_x    <= is_bne_d;
      lw_x     <= is_lw_d;
      sw_x     <= is_sw_d;
      mtc0_x   <= is_mtc0_d;
      alu_fn_x <= alu_fn_d;
    end
    if (reg_en_m)
    begin
      wen_m   <= wen_x;
      waddr_m <= waddr_x;
      lw_m    <= lw_x;
      mtc0_m  <= mtc0_x;
    end
    if (reg_en_w)
    begin
      wen_w   <= wen_m;
      waddr_w <= waddr_m;
      mtc0_w  <= mtc0_m;
    end
  end

endmodule

// File: source/proc_dpath.sv
/* PC starts at zero; register 0 always reads as zero
   Stage registers hold garbage while their valid bit in the control unit is low */
`timescale 1ns/100ps

module proc_dpath
(
  input  logic                clk,
  input  logic                arst_n,
  output proc_pkg::word_t     fetch_addr,
  input  proc_pkg::word_t     imemresp_data,
  output proc_pkg::word_t     dmemreq_addr,
  output proc_pkg::word_t     dmemreq_data,
  input  proc_pkg::word_t     dmemresp_data,
  input  proc_pkg::word_t     from_mngr_data,
  output proc_pkg::word_t     to_mngr_data,
  input  proc_pkg::pc_sel_e   pc_sel_f,
  input  logic                reg_en_f,
  input  logic                reg_en_d,
  input  logic                reg_en_x,
  input  logic                reg_en_m,
  input  logic                reg_en_w,
  input  logic                op1_sel_d,
  input  logic                mngr_sel_d,
  input  proc_pkg::alu_fn_e   alu_fn_x,
  input  logic                wb_sel_m,
  input  proc_pkg::reg_addr_t rf_waddr_w,
  input  logic                rf_wen_w,
  output proc_pkg::word_t     inst_d,
  output logic                br_cond_eq_x
);
  import proc_pkg::*;

  word_t     pc_f;
  word_t     pc_r;
  word_t     pc_d;
  word_t     rf [32];
  reg_addr_t rs_addr_d;
  reg_addr_t rt_addr_d;
  word_t     rs_val_d;
  word_t     rt_val_d;
  word_t     imm_d;
  word_t     op1_d;
  word_t     br_target_d;
  word_t     op0_x;
  word_t     op1_x;
  word_t     sd_x;
  word_t     br_target_x;
  word_t     alu_out_x;
  word_t     result_m;
  word_t     result_w;

  // ------------------------------------------------------------------
  // Fetch
  // ------------------------------------------------------------------

  // pc_f is the next address to request, pc_r the PC of the next kept response
  assign fetch_addr = pc_f;

  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      pc_f <= '0;
      pc_r <= '0;
    end
    else
    begin
      if (reg_en_f)
        pc_f <= (pc_sel_f == pc_branch) ? br_target_x : pc_f + 32'd4;
      if (reg_en_f && (pc_sel_f == pc_branch))
        pc_r <= br_target_x;
      else if (reg_en_d)
        pc_r <= pc_r + 32'd4;
    end

  // ------------------------------------------------------------------
  // Decode and register read
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
    if (reg_en_d)
    begin
      inst_d <= imemresp_data;
      pc_d   <= pc_r;
    end

  assign rs_addr_d = inst_d[25:21];
  assign rt_addr_d = inst_d[20:16];
  assign rs_val_d  = (rs_addr_d == 5'd0) ? '0 : rf[rs_addr_d];
  assign rt_val_d  = (rt_addr_d == 5'd0) ? '0 : rf[rt_addr_d];

  assign imm_d       = {{16{inst_d[15]}}, inst_d[15:0]};
  assign br_target_d = pc_d + 32'd4 + {imm_d[29:0], 2'b00};
  assign op1_d       = mngr_sel_d ? from_mngr_data : (op1_sel_d ? imm_d : rt_val_d);

  always_ff @(posedge clk)
    if (rf_wen_w)
      rf[rf_waddr_w] <= result_w;

  // ------------------------------------------------------------------
  // Execute
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
    if (reg_en_x)
    begin
      op0_x       <= rs_val_d;
      op1_x       <= op1_d;
      sd_x        <= rt_val_d;
      br_target_x <= br_target_d;
    end

  always_comb
  begin
    case (alu_fn_x)
      alu_add:    alu_out_x = op0_x + op1_x;
      alu_cmp_eq: alu_out_x = {31'b0, op0_x == op1_x};
      alu_cp_op1: alu_out_x = op1_x;
      default:    alu_out_x = op0_x + op1_x;
    endcase
  end

  // Only meaningful with alu_cmp_eq, which the control unit selects for bne
  assign br_cond_eq_x = alu_out_x[0];

  assign dmemreq_addr = alu_out_x;
  assign dmemreq_data = sd_x;

  // ------------------------------------------------------------------
  // Memory and writeback
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reg_en_m)
      result_m <= alu_out_x;
    if (reg_en_w)
      result_w <= wb_sel_m ? dmemresp_data : result_m;
  end

  assign to_mngr_data = result_w;

endmodule

// File: source/proc_imem_queue.sv
/* Two entries; a request passes through in the same cycle only when empty
   enq_rdy depends on the fill level alone, never on enq_val */
`timescale 1ns/100ps

module proc_imem_queue
(
  input  logic            clk,
  input  logic            arst_n,
  input  proc_pkg::word_t enq_addr,
  input  logic            enq_val,
  output logic            enq_rdy,
  output proc_pkg::word_t deq_addr,
  output logic            deq_val,
  input  logic            deq_rdy
);
  import proc_pkg::*;

  word_t      entry [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       empty;
  logic       enq_go;
  logic       deq_go;
  logic       do_write;
  logic       do_read;

  assign empty    = (count == 2'd0);
  assign enq_rdy  = (count != 2'd2);
  assign deq_val  = !empty || enq_val;
  assign deq_addr = empty ? enq_addr : entry[rd_ptr];
  assign enq_go   = enq_val && enq_rdy;
  assign deq_go   = deq_val && deq_rdy;

  // Bypass when empty and the memory takes it right away
  assign do_write = enq_go && !(empty && deq_rdy);
  assign do_read  = deq_go && !empty;

  always_ff @(posedge clk)
    if (do_write)
      entry[wr_ptr] <= enq_addr;

  always_ff @(posedge clk or negedge arst_n)
    if (!arst_n)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= !wr_ptr;
      if (do_read)
        rd_ptr <= !rd_ptr;
      count <= count + {1'b0, do_write} - {1'b0, do_read};
    end

endmodule

// File: source/proc_pkg.sv
/* Word-only subset of a MIPS-like ISA: addu, addiu, lw, sw, bne, mfc0, mtc0
   Memory requests carry no opaque, length or byte-enable fields */
package proc_pkg;

  // ------------------------------------------------------------------
  // Word types
  // ------------------------------------------------------------------

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [0:0]  memreq_type_t;

  // ------------------------------------------------------------------
  // Instruction encodings
  // ------------------------------------------------------------------

  // Major opcodes, bits 31:26
  localparam logic [5:0] op_special = 6'b000000;
  localparam logic [5:0] op_addiu   = 6'b001001;
  localparam logic [5:0] op_lw      = 6'b100011;
  localparam logic [5:0] op_sw      = 6'b101011;
  localparam logic [5:0] op_bne     = 6'b000101;
  localparam logic [5:0] op_cop0    = 6'b010000;

  // Function field of op_special, bits 5:0
  localparam logic [5:0] funct_addu = 6'b100001;

  // Coprocessor 0 moves are told apart by the rs field
  localparam logic [4:0] cop0_mf = 5'b00000;
  localparam logic [4:0] cop0_mt = 5'b00100;

  // ------------------------------------------------------------------
  // Memory request type
  // ------------------------------------------------------------------

  localparam memreq_type_t memreq_read  = 1'b0;
  localparam memreq_type_t memreq_write = 1'b1;

  // ------------------------------------------------------------------
  // Datapath selects
  // ------------------------------------------------------------------

  typedef enum logic [1:0]
  {
    alu_add,
    alu_cmp_eq,
    alu_cp_op1
  } alu_fn_e;

  typedef enum logic
  {
    pc_plus4,
    pc_branch
  } pc_sel_e;

endpackage

// File: source/proc_top.sv
/* All ports use val/rdy; a transfer happens on a clk edge with both high
   Memory requests are word-sized; the instruction port only reads */
`timescale 1ns/100ps

module proc_top
(
  input  logic                   clk,
  input  logic                   arst_n,

  // Instruction memory
  output proc_pkg::word_t        imemreq_addr,
  output logic                   imemreq_val,
  input  logic                   imemreq_rdy,
  input  proc_pkg::word_t        imemresp_data,
  input  logic                   imemresp_val,
  output logic                   imemresp_rdy,

  // Data memory
  output proc_pkg::memreq_type_t dmemreq_type,
  output proc_pkg::word_t        dmemreq_addr,
  output proc_pkg::word_t        dmemreq_data,
  output logic                   dmemreq_val,
  input  logic                   dmemreq_rdy,
  input  proc_pkg::word_t        dmemresp_data,
  input  logic                   dmemresp_val,
  output logic                   dmemresp_rdy,

  // Manager streams
  input  proc_pkg::word_t        from_mngr_data,
  input  logic                   from_mngr_val,
  output logic                   from_mngr_rdy,
  output proc_pkg::word_t        to_mngr_data,
  output logic                   to_mngr_val,
  input  logic                   to_mngr_rdy
);
  import proc_pkg::*;

  // Fetch request into the queue
  word_t     fetch_addr;
  logic      fetch_val;
  logic      fetch_rdy;

  // Control to datapath
  pc_sel_e   pc_sel_f;
  logic      reg_en_f;
  logic      reg_en_d;
  logic      reg_en_x;
  logic      reg_en_m;
  logic      reg_en_w;
  logic      op1_sel_d;
  logic      mngr_sel_d;
  logic      wb_sel_m;
  alu_fn_e   alu_fn_x;
  reg_addr_t rf_waddr_w;
  logic      rf_wen_w;

  // Datapath status
  word_t     inst_d;
  logic      br_cond_eq_x;

  // Names line up across both blocks
  proc_ctrl ctrl (.*);

  proc_dpath dpath (.*);

  proc_imem_queue imem_queue
  (
    .clk      (clk),
    .arst_n   (arst_n),
    .enq_addr (fetch_addr),
    .enq_val  (fetch_val),
    .enq_rdy  (fetch_rdy),
    .deq_addr (imemreq_addr),
    .deq_val  (imemreq_val),
    .deq_rdy  (imemreq_rdy)
  );

endmodule

// File: tb.f
source/proc_pkg.sv
source/proc_imem_queue.sv
source/proc_ctrl.sv
source/proc_dpath.sv
source/proc_top.sv
sim/proc_props.sv
sim/tb_proc.sv
